/* design/mci_config.svh */
`ifndef MCI_CONFIG_SVH
`define MCI_CONFIG_SVH

// Register port widths
`define MCI_DATA_W 32
`define MCI_ADDR_W 4

// Aggregated error vector width
`define MCI_ERR_W 32

// MCU reset hold counter width, held for 2**W cycles
`define MCI_MCU_RST_CNT_W 4

// Register reset values
`define MCI_WDT_PERIOD_RST 32'hFFFF_FFFF
`define MCI_ERR_MASK_RST {`MCI_ERR_W{1'b0}}

`endif

/* design/mci_boot_pkg.sv */
package mci_boot_pkg;

    // Boot sequencer states
    typedef enum logic [3:0] {
        BOOT_IDLE         = 4'd0,
        BOOT_WAIT_GO      = 4'd1,
        BOOT_LCC_INIT     = 4'd2,
        BOOT_FC_INIT      = 4'd3,
        BOOT_RST_CPTRA    = 4'd4,
        BOOT_RST_MCU      = 4'd5,
        BOOT_DONE         = 4'd6,
        BOOT_HALT_REQ     = 4'd7,
        BOOT_MCU_RST_HOLD = 4'd8
    } boot_fsm_state_e;

endpackage

/* design/mci_reg_pkg.sv */
`include "mci_config.svh"

package mci_reg_pkg;

    // Register word addresses
    typedef enum logic [`MCI_ADDR_W-1:0] {
        REG_BOOT_GO            = 4'd0,
        REG_RESET_REQUEST      = 4'd1,
        REG_WDT_EN             = 4'd2,
        REG_WDT_CTRL           = 4'd3,
        REG_WDT_T1_PERIOD      = 4'd4,
        REG_WDT_T2_PERIOD      = 4'd5,
        REG_ERR_FATAL_MASK     = 4'd6,
        REG_ERR_NON_FATAL_MASK = 4'd7,
        REG_HW_ERR_FATAL       = 4'd8,
        REG_HW_ERR_NON_FATAL   = 4'd9,
        REG_BOOT_STATUS        = 4'd10,
        REG_WDT_STATUS         = 4'd11
    } reg_addr_e;

    // WDT_STATUS fields
    localparam int WDT_T1_BIT = 0;
    localparam int WDT_T2_BIT = 1;

    // BOOT_STATUS fields
    localparam int BOOT_RST_ONCE_BIT = 8;

endpackage

/* design/mci_boot_seqr.sv */
`include "mci_config.svh"

module mci_boot_seqr (
    input  logic clk,
    input  logic arst_n_i,
    input  logic mci_boot_seq_brkpoint_i,
    input  logic mci_bootfsm_go_i,
    input  logic mcu_rst_req_i,
    input  logic lc_done_i,
    input  logic fc_opt_done_i,
    input  logic mcu_cpu_halt_ack_i,
    output logic lc_init_o,
    output logic fc_opt_init_o,
    output logic cptra_rst_b_o,
    output logic mcu_rst_b_o,
    output logic mcu_cpu_halt_req_o,
    output logic mcu_reset_once_o,
    output mci_boot_pkg::boot_fsm_state_e boot_fsm_o
);

    mci_boot_pkg::boot_fsm_state_e state_q;
    mci_boot_pkg::boot_fsm_state_e state_d;
    logic [`MCI_MCU_RST_CNT_W-1:0] rst_cnt_q;
    logic [`MCI_MCU_RST_CNT_W-1:0] rst_cnt_inc;
    logic                          rst_cnt_ovf;

    // Carry out of the hold counter ends the MCU reset
    assign {rst_cnt_ovf, rst_cnt_inc} = {1'b0, rst_cnt_q} + 1'b1;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            mci_boot_pkg::BOOT_IDLE: begin
                state_d = mci_boot_seq_brkpoint_i ? mci_boot_pkg::BOOT_WAIT_GO
                                                  : mci_boot_pkg::BOOT_LCC_INIT;
            end
            mci_boot_pkg::BOOT_WAIT_GO: begin
                if (mci_bootfsm_go_i) state_d = mci_boot_pkg::BOOT_LCC_INIT;
            end
            mci_boot_pkg::BOOT_LCC_INIT: begin
                if (lc_done_i) state_d = mci_boot_pkg::BOOT_FC_INIT;
            end
            mci_boot_pkg::BOOT_FC_INIT: begin
                if (fc_opt_done_i) state_d = mci_boot_pkg::BOOT_RST_CPTRA;
            end
            mci_boot_pkg::BOOT_RST_CPTRA: state_d = mci_boot_pkg::BOOT_RST_MCU;
            mci_boot_pkg::BOOT_RST_MCU:   state_d = mci_boot_pkg::BOOT_DONE;
            mci_boot_pkg::BOOT_DONE: begin
                if (mcu_rst_req_i) state_d = mci_boot_pkg::BOOT_HALT_REQ;
            end
            // Wait for the MCU to park before pulling its reset
            mci_boot_pkg::BOOT_HALT_REQ: begin
                if (mcu_cpu_halt_ack_i) state_d = mci_boot_pkg::BOOT_MCU_RST_HOLD;
            end
            mci_boot_pkg::BOOT_MCU_RST_HOLD: begin
                if (rst_cnt_ovf) state_d = mci_boot_pkg::BOOT_DONE;
            end
            default: state_d = mci_boot_pkg::BOOT_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // State and registered outputs
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q            <= mci_boot_pkg::BOOT_IDLE;
            rst_cnt_q          <= '0;
            lc_init_o          <= 1'b0;
            fc_opt_init_o      <= 1'b0;
            cptra_rst_b_o      <= 1'b0;
            mcu_rst_b_o        <= 1'b0;
            mcu_cpu_halt_req_o <= 1'b0;
            mcu_reset_once_o   <= 1'b0;
        end else begin
            state_q            <= state_d;
            rst_cnt_q          <= (state_q == mci_boot_pkg::BOOT_MCU_RST_HOLD) ? rst_cnt_inc : '0;
            lc_init_o          <= (state_d == mci_boot_pkg::BOOT_LCC_INIT);
            fc_opt_init_o      <= (state_d == mci_boot_pkg::BOOT_FC_INIT);
            // Caliptra stays out of reset once released
            cptra_rst_b_o      <= cptra_rst_b_o || (state_d == mci_boot_pkg::BOOT_RST_MCU);
            mcu_rst_b_o        <= (state_d inside {mci_boot_pkg::BOOT_DONE,
                                                   mci_boot_pkg::BOOT_HALT_REQ});
            mcu_cpu_halt_req_o <= (state_d == mci_boot_pkg::BOOT_HALT_REQ);
            mcu_reset_once_o   <= mcu_reset_once_o ||
                                  ((state_q == mci_boot_pkg::BOOT_MCU_RST_HOLD) && rst_cnt_ovf);
        end
    end

    assign boot_fsm_o = state_q;

endmodule

/* design/mci_wdt.sv */
`include "mci_config.svh"

module mci_wdt (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   wdt_en_i,
    input  logic                   wdt_restart_i,
    input  logic [`MCI_DATA_W-1:0] t1_period_i,
    input  logic [`MCI_DATA_W-1:0] t2_period_i,
    input  logic                   t1_service_i,
    input  logic                   t2_service_i,
    output logic                   t1_timeout_o,
    output logic                   t2_timeout_o
);

    logic [`MCI_DATA_W-1:0] t1_cnt_q;
    logic [`MCI_DATA_W-1:0] t2_cnt_q;
    logic                   t2_run;

    // Timer 2 runs in cascade behind timer 1
    assign t2_run = wdt_en_i && t1_timeout_o && !t2_timeout_o;

    ////////////////////////////////////////
    // Timer 1
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            t1_cnt_q     <= '0;
            t1_timeout_o <= 1'b0;
        end else if (t1_service_i) begin
            t1_cnt_q     <= '0;
            t1_timeout_o <= 1'b0;
        end else if (wdt_restart_i || !wdt_en_i) begin
            t1_cnt_q <= '0;
        end else if (!t1_timeout_o) begin
            if (t1_cnt_q == t1_period_i) t1_timeout_o <= 1'b1;
            else t1_cnt_q <= t1_cnt_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Timer 2
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            t2_cnt_q     <= '0;
            t2_timeout_o <= 1'b0;
        end else begin
            if (t1_service_i || !t1_timeout_o) begin
                t2_cnt_q <= '0;
            end else if (t2_run) begin
                if (t2_cnt_q == t2_period_i) t2_timeout_o <= 1'b1;
                else t2_cnt_q <= t2_cnt_q + 1'b1;
            end
            // Service wins over a same-cycle expiry
            if (t2_service_i) t2_timeout_o <= 1'b0;
        end
    end

endmodule

/* design/mci_err_agg.sv */
`include "mci_config.svh"

module mci_err_agg (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [`MCI_ERR_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_ERR_W-1:0] agg_error_non_fatal_i,
    input  logic [`MCI_ERR_W-1:0] fatal_mask_i,
    input  logic [`MCI_ERR_W-1:0] non_fatal_mask_i,
    input  logic [`MCI_ERR_W-1:0] fatal_clr_i,
    input  logic [`MCI_ERR_W-1:0] non_fatal_clr_i,
    output logic [`MCI_ERR_W-1:0] fatal_sts_o,
    output logic [`MCI_ERR_W-1:0] non_fatal_sts_o,
    output logic                  all_error_fatal_o,
    output logic                  all_error_non_fatal_o
);

    // Channel 0 is fatal, channel 1 is non-fatal
    logic [1:0][`MCI_ERR_W-1:0] err_in;
    logic [1:0][`MCI_ERR_W-1:0] err_mask;
    logic [1:0][`MCI_ERR_W-1:0] err_clr;
    logic [1:0][`MCI_ERR_W-1:0] err_sts_q;
    logic [1:0]                 err_sum_q;

    assign err_in   = {agg_error_non_fatal_i, agg_error_fatal_i};
    assign err_mask = {non_fatal_mask_i, fatal_mask_i};
    assign err_clr  = {non_fatal_clr_i, fatal_clr_i};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_sts_q <= '0;
            err_sum_q <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                // A live error input overrides the W1C
                err_sts_q[ch] <= (err_sts_q[ch] & ~err_clr[ch]) | err_in[ch];
                err_sum_q[ch] <= |(err_sts_q[ch] & ~err_mask[ch]);
            end
        end
    end

    assign fatal_sts_o           = err_sts_q[0];
    assign non_fatal_sts_o       = err_sts_q[1];
    assign all_error_fatal_o     = err_sum_q[0];
    assign all_error_non_fatal_o = err_sum_q[1];

endmodule

/* design/mci_reg.sv */
`include "mci_config.svh"

module mci_reg (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          reg_we_i,
    input  logic                          reg_re_i,
    input  logic [`MCI_ADDR_W-1:0]        reg_addr_i,
    input  logic [`MCI_DATA_W-1:0]        reg_wdata_i,
    input  mci_boot_pkg::boot_fsm_state_e boot_fsm_i,
    input  logic                          mcu_reset_once_i,
    input  logic                          t1_timeout_i,
    input  logic                          t2_timeout_i,
    input  logic [`MCI_ERR_W-1:0]         fatal_sts_i,
    input  logic [`MCI_ERR_W-1:0]         non_fatal_sts_i,
    output logic [`MCI_DATA_W-1:0]        reg_rdata_o,
    output logic                          mci_bootfsm_go_o,
    output logic                          mcu_rst_req_o,
    output logic                          wdt_en_o,
    output logic                          wdt_restart_o,
    output logic [`MCI_DATA_W-1:0]        t1_period_o,
    output logic [`MCI_DATA_W-1:0]        t2_period_o,
    output logic                          t1_service_o,
    output logic                          t2_service_o,
    output logic [`MCI_ERR_W-1:0]         fatal_mask_o,
    output logic [`MCI_ERR_W-1:0]         non_fatal_mask_o,
    output logic [`MCI_ERR_W-1:0]         fatal_clr_o,
    output logic [`MCI_ERR_W-1:0]         non_fatal_clr_o
);

    mci_reg_pkg::reg_addr_e addr;
    logic [`MCI_DATA_W-1:0] rdata_d;
    logic                   wr_fatal;
    logic                   wr_non_fatal;
    logic                   wr_wdt_sts;

    assign addr         = mci_reg_pkg::reg_addr_e'(reg_addr_i);
    assign wr_fatal     = reg_we_i && (addr == mci_reg_pkg::REG_HW_ERR_FATAL);
    assign wr_non_fatal = reg_we_i && (addr == mci_reg_pkg::REG_HW_ERR_NON_FATAL);
    assign wr_wdt_sts   = reg_we_i && (addr == mci_reg_pkg::REG_WDT_STATUS);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mci_bootfsm_go_o <= 1'b0;
            wdt_en_o         <= 1'b0;
            t1_period_o      <= `MCI_WDT_PERIOD_RST;
            t2_period_o      <= `MCI_WDT_PERIOD_RST;
            fatal_mask_o     <= `MCI_ERR_MASK_RST;
            non_fatal_mask_o <= `MCI_ERR_MASK_RST;
        end else if (reg_we_i) begin
            case (addr)
                mci_reg_pkg::REG_BOOT_GO:            mci_bootfsm_go_o <= reg_wdata_i[0];
                mci_reg_pkg::REG_WDT_EN:             wdt_en_o <= reg_wdata_i[0];
                mci_reg_pkg::REG_WDT_T1_PERIOD:      t1_period_o <= reg_wdata_i;
                mci_reg_pkg::REG_WDT_T2_PERIOD:      t2_period_o <= reg_wdata_i;
                mci_reg_pkg::REG_ERR_FATAL_MASK:     fatal_mask_o <= reg_wdata_i[`MCI_ERR_W-1:0];
                mci_reg_pkg::REG_ERR_NON_FATAL_MASK: non_fatal_mask_o <= reg_wdata_i[`MCI_ERR_W-1:0];
                default: ;
            endcase
        end
    end

    // Self-clearing pulses, one cycle after the write
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mcu_rst_req_o   <= 1'b0;
            wdt_restart_o   <= 1'b0;
            t1_service_o    <= 1'b0;
            t2_service_o    <= 1'b0;
            fatal_clr_o     <= '0;
            non_fatal_clr_o <= '0;
        end else begin
            mcu_rst_req_o   <= reg_we_i && (addr == mci_reg_pkg::REG_RESET_REQUEST) &&
                               reg_wdata_i[0];
            wdt_restart_o   <= reg_we_i && (addr == mci_reg_pkg::REG_WDT_CTRL) && reg_wdata_i[0];
            t1_service_o    <= wr_wdt_sts && reg_wdata_i[mci_reg_pkg::WDT_T1_BIT];
            t2_service_o    <= wr_wdt_sts && reg_wdata_i[mci_reg_pkg::WDT_T2_BIT];
            fatal_clr_o     <= wr_fatal ? reg_wdata_i[`MCI_ERR_W-1:0] : '0;
            non_fatal_clr_o <= wr_non_fatal ? reg_wdata_i[`MCI_ERR_W-1:0] : '0;
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        rdata_d = '0;
        case (addr)
            mci_reg_pkg::REG_BOOT_GO:            rdata_d[0] = mci_bootfsm_go_o;
            mci_reg_pkg::REG_WDT_EN:             rdata_d[0] = wdt_en_o;
            mci_reg_pkg::REG_WDT_T1_PERIOD:      rdata_d = t1_period_o;
            mci_reg_pkg::REG_WDT_T2_PERIOD:      rdata_d = t2_period_o;
            mci_reg_pkg::REG_ERR_FATAL_MASK:     rdata_d[`MCI_ERR_W-1:0] = fatal_mask_o;
            mci_reg_pkg::REG_ERR_NON_FATAL_MASK: rdata_d[`MCI_ERR_W-1:0] = non_fatal_mask_o;
            mci_reg_pkg::REG_HW_ERR_FATAL:       rdata_d[`MCI_ERR_W-1:0] = fatal_sts_i;
            mci_reg_pkg::REG_HW_ERR_NON_FATAL:   rdata_d[`MCI_ERR_W-1:0] = non_fatal_sts_i;
            mci_reg_pkg::REG_BOOT_STATUS: begin
                rdata_d[$bits(boot_fsm_i)-1:0]           = boot_fsm_i;
                rdata_d[mci_reg_pkg::BOOT_RST_ONCE_BIT] = mcu_reset_once_i;
            end
            mci_reg_pkg::REG_WDT_STATUS: begin
                rdata_d[mci_reg_pkg::WDT_T1_BIT] = t1_timeout_i;
                rdata_d[mci_reg_pkg::WDT_T2_BIT] = t2_timeout_i;
            end
            // Pulse registers and holes read zero
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) reg_rdata_o <= '0;
        else if (reg_re_i) reg_rdata_o <= rdata_d;
    end

endmodule

/* design/mci_top.sv */
`include "mci_config.svh"

module mci_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // Register port
    input  logic                   reg_we_i,
    input  logic                   reg_re_i,
    input  logic [`MCI_ADDR_W-1:0] reg_addr_i,
    input  logic [`MCI_DATA_W-1:0] reg_wdata_i,
    output logic [`MCI_DATA_W-1:0] reg_rdata_o,
    // Boot control
    input  logic                   mci_boot_seq_brkpoint_i,
    input  logic                   lc_done_i,
    output logic                   lc_init_o,
    input  logic                   fc_opt_done_i,
    output logic                   fc_opt_init_o,
    output logic                   cptra_rst_b_o,
    output logic                   mcu_rst_b_o,
    output logic                   mcu_cpu_halt_req_o,
    input  logic                   mcu_cpu_halt_ack_i,
    // Errors and interrupts
    input  logic [`MCI_ERR_W-1:0]  agg_error_fatal_i,
    input  logic [`MCI_ERR_W-1:0]  agg_error_non_fatal_i,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,
    output logic                   mcu_timer_int_o,
    output logic                   nmi_intr_o
);

    mci_boot_pkg::boot_fsm_state_e boot_fsm;
    logic                   mci_bootfsm_go;
    logic                   mcu_rst_req;
    logic                   mcu_reset_once;
    logic                   wdt_en;
    logic                   wdt_restart;
    logic                   t1_service;
    logic                   t2_service;
    logic                   t1_timeout;
    logic                   t2_timeout;
    logic [`MCI_DATA_W-1:0] t1_period;
    logic [`MCI_DATA_W-1:0] t2_period;
    logic [`MCI_ERR_W-1:0]  fatal_mask;
    logic [`MCI_ERR_W-1:0]  non_fatal_mask;
    logic [`MCI_ERR_W-1:0]  err_fatal_clr;
    logic [`MCI_ERR_W-1:0]  err_non_fatal_clr;
    logic [`MCI_ERR_W-1:0]  fatal_sts;
    logic [`MCI_ERR_W-1:0]  non_fatal_sts;

    mci_boot_seqr u_boot_seqr (
        .clk,
        .arst_n_i,
        .mci_boot_seq_brkpoint_i,
        .mci_bootfsm_go_i  (mci_bootfsm_go),
        .mcu_rst_req_i     (mcu_rst_req),
        .lc_done_i,
        .fc_opt_done_i,
        .mcu_cpu_halt_ack_i,
        .lc_init_o,
        .fc_opt_init_o,
        .cptra_rst_b_o,
        .mcu_rst_b_o,
        .mcu_cpu_halt_req_o,
        .mcu_reset_once_o  (mcu_reset_once),
        .boot_fsm_o        (boot_fsm)
    );

    mci_wdt u_wdt (
        .clk,
        .arst_n_i,
        .wdt_en_i      (wdt_en),
        .wdt_restart_i (wdt_restart),
        .t1_period_i   (t1_period),
        .t2_period_i   (t2_period),
        .t1_service_i  (t1_service),
        .t2_service_i  (t2_service),
        .t1_timeout_o  (t1_timeout),
        .t2_timeout_o  (t2_timeout)
    );

    // Timer 1 expiry interrupts the MCU, timer 2 expiry is the NMI
    assign mcu_timer_int_o = t1_timeout;
    assign nmi_intr_o      = t2_timeout;

    mci_err_agg u_err_agg (
        .clk,
        .arst_n_i,
        .agg_error_fatal_i,
        .agg_error_non_fatal_i,
        .fatal_mask_i     (fatal_mask),
        .non_fatal_mask_i (non_fatal_mask),
        .fatal_clr_i      (err_fatal_clr),
        .non_fatal_clr_i  (err_non_fatal_clr),
        .fatal_sts_o      (fatal_sts),
        .non_fatal_sts_o  (non_fatal_sts),
        .all_error_fatal_o,
        .all_error_non_fatal_o
    );

    mci_reg u_reg (
        .clk,
        .arst_n_i,
        .reg_we_i,
        .reg_re_i,
        .reg_addr_i,
        .reg_wdata_i,
        .boot_fsm_i       (boot_fsm),
        .mcu_reset_once_i (mcu_reset_once),
        .t1_timeout_i     (t1_timeout),
        .t2_timeout_i     (t2_timeout),
        .fatal_sts_i      (fatal_sts),
        .non_fatal_sts_i  (non_fatal_sts),
        .reg_rdata_o,
        .mci_bootfsm_go_o (mci_bootfsm_go),
        .mcu_rst_req_o    (mcu_rst_req),
        .wdt_en_o         (wdt_en),
        .wdt_restart_o    (wdt_restart),
        .t1_period_o      (t1_period),
        .t2_period_o      (t2_period),
        .t1_service_o     (t1_service),
        .t2_service_o     (t2_service),
        .fatal_mask_o     (fatal_mask),
        .non_fatal_mask_o (non_fatal_mask),
        .fatal_clr_o      (err_fatal_clr),
        .non_fatal_clr_o  (err_non_fatal_clr)
    );

endmodule

/* testbench/mci_top_tb.sv */
`include "mci_config.svh"

module mci_top_tb;

    // Sum of the table waits is well under 900 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    // Table operations
    localparam logic [2:0] OP_WR   = 3'd0;
    localparam logic [2:0] OP_RD   = 3'd1;
    localparam logic [2:0] OP_WAIT = 3'd2;
    localparam logic [2:0] OP_HOLD = 3'd3;
    localparam logic [2:0] OP_ERR  = 3'd4;

    // Watched DUT outputs
    localparam logic [3:0] SIG_LC_INIT       = 4'd0;
    localparam logic [3:0] SIG_FC_INIT       = 4'd1;
    localparam logic [3:0] SIG_CPTRA_RST     = 4'd2;
    localparam logic [3:0] SIG_MCU_RST       = 4'd3;
    localparam logic [3:0] SIG_HALT_REQ      = 4'd4;
    localparam logic [3:0] SIG_ERR_FATAL     = 4'd5;
    localparam logic [3:0] SIG_ERR_NON_FATAL = 4'd6;
    localparam logic [3:0] SIG_TIMER_INT     = 4'd7;
    localparam logic [3:0] SIG_NMI           = 4'd8;

    // Table row whose sel holds a register address, a signal or an error channel
    typedef struct packed {
        logic [2:0]             op;
        logic [3:0]             sel;
        logic [`MCI_DATA_W-1:0] data;
        logic [`MCI_DATA_W-1:0] exp;
    } step_t;

    logic                   clk;
    logic                   arst_n_i;
    logic                   reg_we_i;
    logic                   reg_re_i;
    logic [`MCI_ADDR_W-1:0] reg_addr_i;
    logic [`MCI_DATA_W-1:0] reg_wdata_i;
    logic [`MCI_DATA_W-1:0] reg_rdata_o;
    logic                   mci_boot_seq_brkpoint_i;
    logic                   lc_done_i;
    logic                   lc_init_o;
    logic                   fc_opt_done_i;
    logic                   fc_opt_init_o;
    logic                   cptra_rst_b_o;
    logic                   mcu_rst_b_o;
    logic                   mcu_cpu_halt_req_o;
    logic                   mcu_cpu_halt_ack_i;
    logic [`MCI_ERR_W-1:0]  agg_error_fatal_i;
    logic [`MCI_ERR_W-1:0]  agg_error_non_fatal_i;
    logic                   all_error_fatal_o;
    logic                   all_error_non_fatal_o;
    logic                   mcu_timer_int_o;
    logic                   nmi_intr_o;

    step_t       steps[$];
    int unsigned cycle_cnt;
    int unsigned lc_delay;
    int unsigned fc_delay;
    int unsigned ack_delay;
    int unsigned fatal_bit;
    int unsigned non_fatal_bit;
    logic        lc_done_seen;

    mci_top uut (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////
    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, exp, act);
        stop_run();
    endtask

    function automatic logic sig_value(input logic [3:0] sel);
        case (sel)
            SIG_LC_INIT:       return lc_init_o;
            SIG_FC_INIT:       return fc_opt_init_o;
            SIG_CPTRA_RST:     return cptra_rst_b_o;
            SIG_MCU_RST:       return mcu_rst_b_o;
            SIG_HALT_REQ:      return mcu_cpu_halt_req_o;
            SIG_ERR_FATAL:     return all_error_fatal_o;
            SIG_ERR_NON_FATAL: return all_error_non_fatal_o;
            SIG_TIMER_INT:     return mcu_timer_int_o;
            SIG_NMI:           return nmi_intr_o;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic string sig_name(input logic [3:0] sel);
        case (sel)
            SIG_LC_INIT:       return "lc_init_o";
            SIG_FC_INIT:       return "fc_opt_init_o";
            SIG_CPTRA_RST:     return "cptra_rst_b_o";
            SIG_MCU_RST:       return "mcu_rst_b_o";
            SIG_HALT_REQ:      return "mcu_cpu_halt_req_o";
            SIG_ERR_FATAL:     return "all_error_fatal_o";
            SIG_ERR_NON_FATAL: return "all_error_non_fatal_o";
            SIG_TIMER_INT:     return "mcu_timer_int_o";
            SIG_NMI:           return "nmi_intr_o";
            default:           return "unknown";
        endcase
    endfunction

    ////////////////////////////////////////
    // Row operations
    ////////////////////////////////////////
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_we_i    = 1'b0;
    endtask

    // Read data is registered one cycle after the strobe
    task automatic read_check(input logic [3:0] addr, input logic [31:0] exp);
        reg_re_i   = 1'b1;
        reg_addr_i = addr;
        @(negedge clk);
        reg_re_i   = 1'b0;
        assert (reg_rdata_o === exp)
            else value_error($sformatf("reg_rdata_o @0x%0h", addr), exp, reg_rdata_o);
    endtask

    // A nonzero cycle count must match the latency exactly
    task automatic wait_level(input logic [3:0] sel, input logic lvl,
                              input int unsigned cycles);
        int unsigned n;
        n = 0;
        while (sig_value(sel) !== lvl) begin
            @(negedge clk);
            n++;
            if (cycles != 0 && n > cycles) break;
        end
        if (cycles != 0) begin
            assert (n == cycles)
                else value_error({sig_name(sel), " latency"}, cycles, n);
        end
    endtask

    task automatic hold_check(input logic [3:0] sel, input logic lvl,
                              input int unsigned cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (sig_value(sel) === lvl)
                else value_error(sig_name(sel), lvl, sig_value(sel));
        end
    endtask

    task automatic drive_error(input logic [3:0] sel, input logic [31:0] data);
        if (sel == 4'd0) agg_error_fatal_i = data;
        else agg_error_non_fatal_i = data;
    endtask

    task automatic run_step(input step_t s);
        case (s.op)
            OP_WR:   write_reg(s.sel, s.data);
            OP_RD:   read_check(s.sel, s.exp);
            OP_WAIT: wait_level(s.sel, s.exp[0], s.data);
            OP_HOLD: hold_check(s.sel, s.exp[0], s.data);
            OP_ERR:  drive_error(s.sel, s.data);
            default: begin
                $display("Unknown operation in the stimulus table");
                stop_run();
            end
        endcase
    endtask

    task automatic add_step(input logic [2:0] op, input logic [3:0] sel,
                            input logic [31:0] data, input logic [31:0] exp);
        steps.push_back({op, sel, data, exp});
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    task automatic build_table();
        logic [31:0] fbit;
        logic [31:0] nbit;
        logic [31:0] boot_done;
        fbit      = 32'd1 << fatal_bit;
        nbit      = 32'd1 << non_fatal_bit;
        boot_done = 32'(mci_boot_pkg::BOOT_DONE);
        // Boot held at the breakpoint until the go bit
        add_step(OP_HOLD, SIG_LC_INIT, 20, 0);
        add_step(OP_WR, mci_reg_pkg::REG_BOOT_GO, 1, 0);
        add_step(OP_WAIT, SIG_LC_INIT, 0, 1);
        add_step(OP_WAIT, SIG_FC_INIT, 0, 1);
        add_step(OP_WAIT, SIG_CPTRA_RST, 0, 1);
        add_step(OP_WAIT, SIG_MCU_RST, 1, 1);
        add_step(OP_RD, mci_reg_pkg::REG_BOOT_STATUS, 0, boot_done);
        // Readback
        add_step(OP_WR, mci_reg_pkg::REG_WDT_T1_PERIOD, 20, 0);
        add_step(OP_WR, mci_reg_pkg::REG_WDT_T2_PERIOD, 30, 0);
        add_step(OP_WR, mci_reg_pkg::REG_ERR_FATAL_MASK, 32'hA5A5_5A5A, 0);
        add_step(OP_WR, mci_reg_pkg::REG_ERR_NON_FATAL_MASK, nbit, 0);
        add_step(OP_RD, mci_reg_pkg::REG_WDT_T1_PERIOD, 0, 20);
        add_step(OP_RD, mci_reg_pkg::REG_WDT_T2_PERIOD, 0, 30);
        add_step(OP_RD, mci_reg_pkg::REG_ERR_FATAL_MASK, 0, 32'hA5A5_5A5A);
        add_step(OP_RD, mci_reg_pkg::REG_ERR_NON_FATAL_MASK, 0, nbit);
        add_step(OP_RD, 4'hC, 0, 0);
        add_step(OP_RD, 4'hF, 0, 0);
        add_step(OP_WR, mci_reg_pkg::REG_ERR_FATAL_MASK, 0, 0);
        // Unmasked fatal error, then W1C
        add_step(OP_ERR, 0, fbit, 0);
        add_step(OP_WAIT, SIG_ERR_FATAL, 2, 1);
        add_step(OP_RD, mci_reg_pkg::REG_HW_ERR_FATAL, 0, fbit);
        add_step(OP_ERR, 0, 0, 0);
        add_step(OP_WR, mci_reg_pkg::REG_HW_ERR_FATAL, fbit, 0);
        add_step(OP_WAIT, SIG_ERR_FATAL, 0, 0);
        add_step(OP_RD, mci_reg_pkg::REG_HW_ERR_FATAL, 0, 0);
        // Masked non-fatal error
        add_step(OP_ERR, 1, nbit, 0);
        add_step(OP_HOLD, SIG_ERR_NON_FATAL, 5, 0);
        add_step(OP_RD, mci_reg_pkg::REG_HW_ERR_NON_FATAL, 0, nbit);
        add_step(OP_ERR, 1, 0, 0);
        // Sticky status shows up once the mask drops
        add_step(OP_WR, mci_reg_pkg::REG_ERR_NON_FATAL_MASK, 0, 0);
        add_step(OP_WAIT, SIG_ERR_NON_FATAL, 1, 1);
        add_step(OP_WR, mci_reg_pkg::REG_HW_ERR_NON_FATAL, nbit, 0);
        add_step(OP_WAIT, SIG_ERR_NON_FATAL, 0, 0);
        add_step(OP_RD, mci_reg_pkg::REG_HW_ERR_NON_FATAL, 0, 0);
        // Watchdog cascade where t2 counts 30 + 1 cycles after t1 expires
        add_step(OP_WR, mci_reg_pkg::REG_WDT_EN, 1, 0);
        add_step(OP_WAIT, SIG_TIMER_INT, 21, 1);
        add_step(OP_WAIT, SIG_NMI, 31, 1);
        add_step(OP_RD, mci_reg_pkg::REG_WDT_STATUS, 0, 3);
        add_step(OP_WR, mci_reg_pkg::REG_WDT_STATUS, 3, 0);
        add_step(OP_WAIT, SIG_TIMER_INT, 1, 0);
        add_step(OP_WAIT, SIG_NMI, 0, 0);
        add_step(OP_WR, mci_reg_pkg::REG_WDT_EN, 0, 0);
        add_step(OP_RD, mci_reg_pkg::REG_WDT_STATUS, 0, 0);
        // MCU reset request
        add_step(OP_WR, mci_reg_pkg::REG_RESET_REQUEST, 1, 0);
        add_step(OP_WAIT, SIG_HALT_REQ, 0, 1);
        add_step(OP_WAIT, SIG_MCU_RST, 0, 0);
        add_step(OP_WAIT, SIG_MCU_RST, 16, 1);
        add_step(OP_RD, mci_reg_pkg::REG_BOOT_STATUS, 0,
                 boot_done | (32'd1 << mci_reg_pkg::BOOT_RST_ONCE_BIT));
    endtask

    ////////////////////////////////////////
    // Peripheral models and monitors
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (lc_init_o === 1'b1 && !lc_done_i) begin
            repeat (lc_delay) @(negedge clk);
            lc_done_i    = 1'b1;
            lc_done_seen = 1'b1;
            @(negedge clk);
            lc_done_i = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (fc_opt_init_o === 1'b1 && !fc_opt_done_i) begin
            repeat (fc_delay) @(negedge clk);
            fc_opt_done_i = 1'b1;
            @(negedge clk);
            fc_opt_done_i = 1'b0;
        end
    end

    // MCU parks after a random delay
    always @(negedge clk) begin
        if (mcu_cpu_halt_req_o === 1'b1 && !mcu_cpu_halt_ack_i) begin
            repeat (ack_delay) @(negedge clk);
            mcu_cpu_halt_ack_i = 1'b1;
            @(negedge clk);
            mcu_cpu_halt_ack_i = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (arst_n_i) begin
            assert (!(fc_opt_init_o && !lc_done_seen))
                else value_error("fc_opt_init_o", 0, fc_opt_init_o);
            assert (cptra_rst_b_o || !mcu_rst_b_o)
                else value_error("cptra_rst_b_o", 1, cptra_rst_b_o);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out waiting for DUT");
            stop_run();
        end
    end

    initial begin
        clk                     = 1'b0;
        arst_n_i                = 1'b0;
        reg_we_i                = 1'b0;
        reg_re_i                = 1'b0;
        reg_addr_i              = '0;
        reg_wdata_i             = '0;
        mci_boot_seq_brkpoint_i = 1'b1;
        lc_done_i               = 1'b0;
        fc_opt_done_i           = 1'b0;
        mcu_cpu_halt_ack_i      = 1'b0;
        agg_error_fatal_i       = '0;
        agg_error_non_fatal_i   = '0;
        cycle_cnt               = 0;
        lc_done_seen            = 1'b0;
        void'($urandom(32'h50d1));
        lc_delay                = 1 + ($urandom % 8);
        fc_delay                = 1 + ($urandom % 8);
        ack_delay               = 1 + ($urandom % 8);
        fatal_bit               = $urandom % `MCI_ERR_W;
        non_fatal_bit           = $urandom % `MCI_ERR_W;
        build_table();
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* mci_top.f */
+incdir+design
design/mci_boot_pkg.sv
design/mci_reg_pkg.sv
design/mci_boot_seqr.sv
design/mci_wdt.sv
design/mci_err_agg.sv
design/mci_reg.sv
design/mci_top.sv
testbench/mci_top_tb.sv
